//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sdram_controller
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
	  echo "simulation ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
src/sdram_pkg.sv
src/request_fifo.sv
src/refresh_timer.sv
src/init_sequencer.sv
src/command_fsm.sv
src/read_capture.sv
src/sdram_controller.sv
verification/sdram_model.sv
verification/tb_sdram_controller.sv

//--- src/command_fsm.sv
module command_fsm
  import sdram_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  logic              i_init_done,
  input  sdram_pins_t       i_init_pins,
  input  logic              i_req_valid,
  input  sdram_req_t        i_req,
  output logic              o_req_ready,
  input  logic              i_refresh_req,
  output logic              o_refresh_ack,
  output sdram_pins_t       o_pins,
  output logic              o_dq_oe,
  output logic [DATA_W-1:0] o_dq_out
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ACTIVATE,
    ST_ACCESS,
    ST_PRECHARGE,
    ST_WAIT,
    ST_REF_PRECHARGE,
    ST_REF_REFRESH
  } fsm_state_e;

  fsm_state_e        state;
  fsm_state_e        next_state;
  logic [WAIT_W-1:0] wait_cnt;   // shared by every wait

  // latched request, decoded once at accept
  logic              wr_q;
  logic [BANK_W-1:0] bank_q;
  logic [ROW_W-1:0]  row_q;
  logic [COL_W-1:0]  col_q;
  logic [DQM_W-1:0]  dqm_q;
  logic [DATA_W-1:0] data_q;
  logic              take;

  // refresh has priority, so a request is only taken when none is pending
  assign o_req_ready = (state == ST_IDLE) && i_init_done && !i_refresh_req && i_req_valid;
  assign take        = o_req_ready;
  assign o_dq_out    = data_q;   // held for the whole request

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      wr_q   <= i_req.wr;
      bank_q <= addr_bank(i_req.addr);
      row_q  <= addr_row(i_req.addr);
      col_q  <= addr_col(i_req.addr);
      dqm_q  <= i_req.be_n;
      data_q <= i_req.data;
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= ST_IDLE;
      next_state    <= ST_IDLE;
      wait_cnt      <= '0;
      o_pins        <= '{cmd: INHIBIT, addr: '0, ba: '0, dqm: '0};
      o_dq_oe       <= 1'b0;
      o_refresh_ack <= 1'b0;
    end
    else
    begin
      o_pins.cmd    <= NOP;
      o_dq_oe       <= 1'b0;
      o_refresh_ack <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (!i_init_done)
            o_pins <= i_init_pins;   // init sequencer owns the bus
          else if (i_refresh_req)
            state <= ST_REF_PRECHARGE;
          else if (take)
            state <= ST_ACTIVATE;
        end
        ST_ACTIVATE:
        begin
          o_pins.cmd  <= ACTIVE;
          o_pins.addr <= row_q;
          o_pins.ba   <= bank_q;
          wait_cnt    <= WAIT_W'(T_RCD_CYCLES);
          next_state  <= ST_ACCESS;
          state       <= ST_WAIT;
        end
        ST_ACCESS:
        begin
          o_pins.cmd  <= wr_q ? WRITE : READ;
          o_pins.addr <= ROW_W'(col_q);   // pin 10 low, no auto precharge
          o_pins.ba   <= bank_q;
          o_pins.dqm  <= dqm_q;
          o_dq_oe     <= wr_q;
          wait_cnt    <= WAIT_W'(T_WR_CYCLES);  // reads use the same gap
          next_state  <= ST_PRECHARGE;
          state       <= ST_WAIT;
        end
        ST_PRECHARGE:
        begin
          o_pins.cmd  <= PRECHARGE;
          o_pins.addr <= '0;         // this bank only
          o_pins.ba   <= bank_q;
          wait_cnt    <= WAIT_W'(T_RP_CYCLES);
          next_state  <= ST_IDLE;
          state       <= ST_WAIT;
        end
        ST_REF_PRECHARGE:
        begin
          o_pins.cmd  <= PRECHARGE;
          o_pins.addr <= '1;         // all banks
          wait_cnt    <= WAIT_W'(T_RP_CYCLES);
          next_state  <= ST_REF_REFRESH;
          state       <= ST_WAIT;
        end
        ST_REF_REFRESH:
        begin
          o_pins.cmd    <= AUTO_REFRESH;
          o_refresh_ack <= 1'b1;
          wait_cnt      <= WAIT_W'(T_RFC_CYCLES);
          next_state    <= ST_IDLE;
          state         <= ST_WAIT;
        end
        default:   // ST_WAIT
        begin
          if (wait_cnt > 1)
            wait_cnt <= wait_cnt - 1'b1;
          else
            state <= next_state;
        end
      endcase
    end
  end

  // the init sequence must finish before any row is opened
  a_no_active_before_init: assert property (@(posedge clk) disable iff (!reset_n)
    (o_pins.cmd == ACTIVE) |-> i_init_done);

endmodule

//--- src/init_sequencer.sv
module init_sequencer
  import sdram_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        i_init_wait_over,
  output sdram_pins_t o_pins,
  output logic        o_init_done
);

  localparam int REF_W = $clog2(INIT_REFRESHES + 1);

  typedef enum logic [2:0] {
    S_POWERUP,
    S_PRECHARGE,
    S_REFRESH,
    S_LOAD_MODE,
    S_WAIT,
    S_DONE
  } init_state_e;

  init_state_e       state;
  init_state_e       next_state;   // where S_WAIT goes afterwards
  logic [WAIT_W-1:0] wait_cnt;
  logic [REF_W-1:0]  refs;

  assign o_init_done = (state == S_DONE);  // state never leaves S_DONE

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state      <= S_POWERUP;
      next_state <= S_POWERUP;
      wait_cnt   <= '0;
      refs       <= '0;
      o_pins     <= '{cmd: INHIBIT, addr: '0, ba: '0, dqm: '1};
    end
    else
    begin
      o_pins.cmd <= NOP;
      case (state)
        S_POWERUP:
        begin
          o_pins.cmd <= INHIBIT;
          if (i_init_wait_over)
            state <= S_PRECHARGE;
        end
        S_PRECHARGE:
        begin
          o_pins.cmd  <= PRECHARGE;
          o_pins.addr <= '1;       // pin 10 high, all banks
          wait_cnt    <= WAIT_W'(T_RP_CYCLES);
          next_state  <= S_REFRESH;
          state       <= S_WAIT;
        end
        S_REFRESH:
        begin
          o_pins.cmd <= AUTO_REFRESH;
          refs       <= refs + 1'b1;
          wait_cnt   <= WAIT_W'(T_RFC_CYCLES);
          next_state <= (refs == REF_W'(INIT_REFRESHES - 1)) ? S_LOAD_MODE : S_REFRESH;
          state      <= S_WAIT;
        end
        S_LOAD_MODE:
        begin
          o_pins.cmd  <= LOAD_MODE;
          o_pins.addr <= MODE_WORD;
          o_pins.ba   <= '0;
          wait_cnt    <= WAIT_W'(T_MRD_CYCLES);
          next_state  <= S_DONE;
          state       <= S_WAIT;
        end
        S_WAIT:
        begin
          if (wait_cnt > 1)
            wait_cnt <= wait_cnt - 1'b1;
          else
            state <= next_state;
        end
        default: ;  // S_DONE, nop from here on
      endcase
    end
  end

endmodule

//--- src/read_capture.sv
module read_capture
  import sdram_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  sdram_cmd_e        i_cmd,
  input  logic [DATA_W-1:0] i_dq,
  output logic              o_rsp_valid,
  output logic [DATA_W-1:0] o_rsp_data
);

  logic [CAS_LATENCY-1:0] rd_pipe;   // one bit per outstanding read cycle
  logic [DATA_W-1:0]      dq_q;
  logic                   is_read;

  assign is_read    = (i_cmd == READ);
  assign o_rsp_data = dq_q;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_pipe     <= '0;
      o_rsp_valid <= 1'b0;
    end
    else
    begin
      rd_pipe     <= (rd_pipe << 1) | CAS_LATENCY'(is_read);
      o_rsp_valid <= rd_pipe[CAS_LATENCY-1];  // lines up with dq_q
    end
  end

  always_ff @(posedge clk)
  begin
    dq_q <= i_dq;   // sampled every cycle
  end

endmodule

//--- src/refresh_timer.sv
module refresh_timer #(
  parameter int REFRESH_CYCLES   = 781,
  parameter int INIT_WAIT_CYCLES = 5000
) (
  input  logic clk,
  input  logic reset_n,
  input  logic i_init_done,
  input  logic i_refresh_ack,
  output logic o_init_wait_over,
  output logic o_refresh_req
);

  localparam int MAX_CNT = (INIT_WAIT_CYCLES > REFRESH_CYCLES) ? INIT_WAIT_CYCLES
                                                               : REFRESH_CYCLES;
  localparam int CNT_W   = $clog2(MAX_CNT + 1);

  logic [CNT_W-1:0] count;
  logic             expired;

  assign expired          = (count == '0);
  assign o_init_wait_over = expired && !i_init_done;  // only the first expiry matters

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      count         <= CNT_W'(INIT_WAIT_CYCLES);  // power-up wait first
      o_refresh_req <= 1'b0;
    end
    else
    begin
      count <= expired ? CNT_W'(REFRESH_CYCLES) : count - 1'b1;
      if (expired && i_init_done)
        o_refresh_req <= 1'b1;   // new period wins over a late ack
      else if (i_refresh_ack)
        o_refresh_req <= 1'b0;
    end
  end

endmodule

//--- src/request_fifo.sv
module request_fifo #(
  parameter type payload_t  = logic,
  parameter int  FIFO_DEPTH = 2
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  logic                 push;
  logic                 pop;

  assign o_ready = (count != CNT_W'(FIFO_DEPTH));
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];

  assign push = i_valid && o_ready;
  assign pop  = o_valid && i_ready;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= i_data;
  end

  // pointer wrap and count updates must agree
  a_count_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    (count <= CNT_W'(FIFO_DEPTH)) &&
    ((wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(FIFO_DEPTH)))));

endmodule

//--- src/sdram_controller.sv
module sdram_controller
  import sdram_pkg::*;
#(
  parameter int REFRESH_CYCLES   = 781,
  parameter int INIT_WAIT_CYCLES = 5000,
  parameter int FIFO_DEPTH       = 2
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              i_req_valid,
  input  sdram_req_t        i_req,
  output logic              o_req_ready,
  output logic              o_rsp_valid,
  output logic [DATA_W-1:0] o_rsp_data,
  output sdram_pins_t       o_sdram,
  output logic              o_sdram_cke,
  inout  wire  [DATA_W-1:0] io_sdram_dq
);

  logic              fifo_valid;
  sdram_req_t        fifo_data;
  logic              fsm_ready;
  logic              init_wait_over;
  logic              init_done;
  sdram_pins_t       init_pins;
  sdram_pins_t       pins;
  logic              refresh_req;
  logic              refresh_ack;
  logic              dq_oe;
  logic [DATA_W-1:0] dq_out;

  assign o_sdram     = pins;
  assign o_sdram_cke = 1'b1;
  assign io_sdram_dq = dq_oe ? dq_out : 'z;   // released except during WRITE

  request_fifo #(
    .payload_t  (sdram_req_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_request_fifo (
    .clk     (clk),
    .reset_n (reset_n),
    .i_valid (i_req_valid),
    .i_data  (i_req),
    .o_ready (o_req_ready),
    .o_valid (fifo_valid),
    .o_data  (fifo_data),
    .i_ready (fsm_ready)
  );

  refresh_timer #(
    .REFRESH_CYCLES   (REFRESH_CYCLES),
    .INIT_WAIT_CYCLES (INIT_WAIT_CYCLES)
  ) u_refresh_timer (
    .clk              (clk),
    .reset_n          (reset_n),
    .i_init_done      (init_done),
    .i_refresh_ack    (refresh_ack),
    .o_init_wait_over (init_wait_over),
    .o_refresh_req    (refresh_req)
  );

  init_sequencer u_init_sequencer (
    .clk              (clk),
    .reset_n          (reset_n),
    .i_init_wait_over (init_wait_over),
    .o_pins           (init_pins),
    .o_init_done      (init_done)
  );

  command_fsm u_command_fsm (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_init_done   (init_done),
    .i_init_pins   (init_pins),
    .i_req_valid   (fifo_valid),
    .i_req         (fifo_data),
    .o_req_ready   (fsm_ready),
    .i_refresh_req (refresh_req),
    .o_refresh_ack (refresh_ack),
    .o_pins        (pins),
    .o_dq_oe       (dq_oe),
    .o_dq_out      (dq_out)
  );

  read_capture u_read_capture (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_cmd       (pins.cmd),
    .i_dq        (io_sdram_dq),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_data  (o_rsp_data)
  );

endmodule

//--- src/sdram_pkg.sv
package sdram_pkg;

  localparam int ADDR_W = 22;
  localparam int DATA_W = 16;
  localparam int ROW_W  = 12;   // also the width of the address pins
  localparam int COL_W  = 8;
  localparam int BANK_W = 2;
  localparam int DQM_W  = 2;

  localparam int CAS_LATENCY    = 3;
  localparam int T_RCD_CYCLES   = 2;
  localparam int T_RP_CYCLES    = 2;
  localparam int T_RFC_CYCLES   = 4;
  localparam int T_MRD_CYCLES   = 4;
  localparam int T_WR_CYCLES    = 2;
  localparam int INIT_REFRESHES = 2;
  localparam int WAIT_W         = 3;  // wide enough for the longest wait

  // burst length 1, sequential, cas latency 3, programmed write burst
  localparam logic [ROW_W-1:0] MODE_WORD = 12'b00_0_00_011_0_000;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    INHIBIT      = 4'b1111,
    NOP          = 4'b0111,
    ACTIVE       = 4'b0011,
    READ         = 4'b0101,
    WRITE        = 4'b0100,
    PRECHARGE    = 4'b0010,
    AUTO_REFRESH = 4'b0001,
    LOAD_MODE    = 4'b0000
  } sdram_cmd_e;

  typedef struct packed {
    logic              wr;      // 1 = write
    logic [ADDR_W-1:0] addr;
    logic [DQM_W-1:0]  be_n;    // high bit masks that byte, zero for reads
    logic [DATA_W-1:0] data;
  } sdram_req_t;

  typedef struct packed {
    sdram_cmd_e        cmd;
    logic [ROW_W-1:0]  addr;
    logic [BANK_W-1:0] ba;
    logic [DQM_W-1:0]  dqm;
  } sdram_pins_t;

  // address map: bank {21, 8}, row 20..9, column 7..0
  function automatic logic [BANK_W-1:0] addr_bank(input logic [ADDR_W-1:0] a);
    return {a[21], a[8]};
  endfunction

  function automatic logic [ROW_W-1:0] addr_row(input logic [ADDR_W-1:0] a);
    return a[20:9];
  endfunction

  function automatic logic [COL_W-1:0] addr_col(input logic [ADDR_W-1:0] a);
    return a[7:0];
  endfunction

endpackage

//--- verification/sdram_model.sv
module sdram_model
  import sdram_pkg::*;
(
  input  logic              clk,
  input  logic              reset_n,
  input  sdram_pins_t       i_pins,
  input  logic              i_cke,
  inout  wire  [DATA_W-1:0] io_dq,
  output logic              o_error
);

  localparam int KEY_W = BANK_W + ROW_W + COL_W;
  localparam int BANKS = 1 << BANK_W;

  logic [DATA_W-1:0]      mem [logic [KEY_W-1:0]];   // only touched words stored
  logic [BANKS-1:0]       bank_open;
  logic [ROW_W-1:0]       open_row [BANKS];
  logic                   mode_loaded;
  logic [CAS_LATENCY-1:0] rd_valid;                  // read data pipe, one stage per cycle
  logic [DATA_W-1:0]      rd_data [CAS_LATENCY];
  logic [KEY_W-1:0]       key;
  logic [DATA_W-1:0]      old_word;
  string                  violation;

  // last stage is on the pins CAS_LATENCY cycles after READ
  assign io_dq = rd_valid[CAS_LATENCY-1] ? rd_data[CAS_LATENCY-1] : 'z;

  // unwritten words read back as a pattern of their full address
  function automatic logic [DATA_W-1:0] fill_word(input logic [KEY_W-1:0] k);
    return k[15:0] ^ {k[21:16], k[21:12]} ^ 16'h5a3c;
  endfunction

  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      bank_open   <= '0;
      mode_loaded <= 1'b0;
      rd_valid    <= '0;
      o_error     <= 1'b0;
    end
    else if (i_cke)
    begin
      violation = "";
      rd_valid <= {rd_valid[CAS_LATENCY-2:0], i_pins.cmd == READ};
      for (int i = 1; i < CAS_LATENCY; i++)
        rd_data[i] <= rd_data[i-1];
      case (i_pins.cmd)
        ACTIVE:
        begin
          if (!mode_loaded)
            violation = "ACTIVE before the mode register load";
          else if (bank_open[i_pins.ba])
            violation = "ACTIVE to a bank that is already open";
          bank_open[i_pins.ba] <= 1'b1;
          open_row[i_pins.ba]  <= i_pins.addr;
        end
        READ, WRITE:
        begin
          if (!mode_loaded)
            violation = "READ or WRITE before the mode register load";
          else if (!bank_open[i_pins.ba])
            violation = "READ or WRITE to a closed bank";
          key      = {i_pins.ba, open_row[i_pins.ba], i_pins.addr[COL_W-1:0]};
          old_word = mem.exists(key) ? mem[key] : fill_word(key);
          if (i_pins.cmd == READ)
            rd_data[0] <= old_word;
          else
            mem[key] = {i_pins.dqm[1] ? old_word[15:8] : io_dq[15:8],
                        i_pins.dqm[0] ? old_word[7:0]  : io_dq[7:0]};   // dqm high keeps byte
        end
        PRECHARGE:
        begin
          if (i_pins.addr[10])
            bank_open <= '0;              // all banks
          else
            bank_open[i_pins.ba] <= 1'b0;
        end
        AUTO_REFRESH:
        begin
          if (bank_open != '0)
            violation = "AUTO_REFRESH while a bank is open";
        end
        LOAD_MODE:
          mode_loaded <= 1'b1;
        default: ;
      endcase
      if (violation != "")
      begin
        $display("SDRAM model: %s", violation);
        o_error <= 1'b1;
      end
    end
  end

endmodule

//--- verification/tb_sdram_controller.sv
module tb_sdram_controller
  import sdram_pkg::*;
();

  localparam int REFRESH_CYCLES   = 120;
  localparam int INIT_WAIT_CYCLES = 40;
  localparam int WAIT_LIMIT       = 300;   // cycles per bounded wait
  localparam int TRAFFIC_CYCLES   = 1000;

  logic              clk;
  logic              reset_n;
  logic              req_valid;
  sdram_req_t        req;
  logic              req_ready;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_data;
  sdram_pins_t       sdram_pins;
  logic              sdram_cke;
  wire  [DATA_W-1:0] sdram_dq;
  logic              model_error;

  // scoreboard and bus log
  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] expected_q [$];
  logic [DATA_W-1:0] got_q [$];
  sdram_pins_t       cmd_log [$];   // everything except NOP and INHIBIT
  sdram_pins_t       act_log [$];
  int                read_cycles [$];
  int                cycle;
  int                rsp_count;
  int                refresh_count;
  int                stall_cycles;
  int                error_count;
  int                issued_at;

  sdram_controller #(
    .REFRESH_CYCLES   (REFRESH_CYCLES),
    .INIT_WAIT_CYCLES (INIT_WAIT_CYCLES)
  ) UUT (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_req_ready (req_ready),
    .o_rsp_valid (rsp_valid),
    .o_rsp_data  (rsp_data),
    .o_sdram     (sdram_pins),
    .o_sdram_cke (sdram_cke),
    .io_sdram_dq (sdram_dq)
  );

  sdram_model u_sdram_model (
    .clk     (clk),
    .reset_n (reset_n),
    .i_pins  (sdram_pins),
    .i_cke   (sdram_cke),
    .io_dq   (sdram_dq),
    .o_error (model_error)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, actual, expected));
  endtask

  // bus monitor sampling mid-cycle where every output has settled
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      cycle++;
      if (model_error)
        abort_run("the SDRAM model flagged a protocol violation");
      if (sdram_pins.cmd != NOP && sdram_pins.cmd != INHIBIT)
        cmd_log.push_back(sdram_pins);
      if (sdram_pins.cmd == ACTIVE)
        act_log.push_back(sdram_pins);
      if (sdram_pins.cmd == READ)
        read_cycles.push_back(cycle);
      if (sdram_pins.cmd == AUTO_REFRESH)
        refresh_count++;
      if (req_valid && !req_ready)
        stall_cycles++;
      if (rsp_valid)
      begin
        rsp_count++;
        if (read_cycles.size() == 0)
          abort_run("o_rsp_valid went high with no READ outstanding");
        else
        begin
          issued_at = read_cycles.pop_front();
          check_equal("o_rsp_valid delay", 32'(cycle - issued_at), 32'(CAS_LATENCY + 1));
          got_q.push_back(rsp_data);
        end
      end
    end
  end

  // called 1 unit after a rising edge and returns at the same phase
  task automatic send_request(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DQM_W-1:0] be_n, input logic [DATA_W-1:0] data);
    int waited;
    waited    = 0;
    req_valid = 1'b1;
    req       = '{wr: wr, addr: addr, be_n: be_n, data: data};
    while (!req_ready)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("timed out waiting for the request port to accept a request");
      @(posedge clk);
      #1;
    end
    @(posedge clk);   // transfer edge
    #1;
  endtask

  task automatic stop_requests();
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [DQM_W-1:0] be_n);
    logic [DATA_W-1:0] old;
    old          = shadow.exists(addr) ? shadow[addr] : '0;
    shadow[addr] = {be_n[1] ? old[15:8] : data[15:8], be_n[0] ? old[7:0] : data[7:0]};
    send_request(1'b1, addr, be_n, data);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr);
    expected_q.push_back(shadow[addr]);
    send_request(1'b0, addr, '0, '0);
  endtask

  task automatic drain_responses();
    int                waited;
    logic [DATA_W-1:0] exp_word;
    logic [DATA_W-1:0] got_word;
    waited = 0;
    while (got_q.size() < expected_q.size())
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        abort_run("timed out waiting for read responses");
      @(posedge clk);
      #1;
    end
    while (expected_q.size() > 0)
    begin
      exp_word = expected_q.pop_front();
      got_word = got_q.pop_front();
      check_equal("o_rsp_data", 32'(got_word), 32'(exp_word));
    end
  endtask

  task automatic check_reset_state();
    check_equal("o_sdram.cmd", 32'(sdram_pins.cmd), 32'(INHIBIT));
    check_equal("o_rsp_valid", 32'(rsp_valid), 32'd0);
    check_equal("io_sdram_dq enable", 32'(UUT.dq_oe), 32'd0);
    check_equal("o_req_ready", 32'(req_ready), 32'd1);
    check_equal("o_sdram_cke", 32'(sdram_cke), 32'd1);
  endtask

  task automatic check_init_sequence();
    int waited;
    waited = 0;
    // a write queued now has to wait for the mode load
    write_word(ADDR_W'($urandom()), DATA_W'($urandom()), 2'b00);
    stop_requests();
    while (cmd_log.size() < 4)
    begin
      waited++;
      if (waited > INIT_WAIT_CYCLES + WAIT_LIMIT)
        abort_run("timed out waiting for the init command sequence");
      @(posedge clk);
      #1;
    end
    check_equal("o_sdram.cmd init 0", 32'(cmd_log[0].cmd), 32'(PRECHARGE));
    check_equal("o_sdram.addr[10] init 0", 32'(cmd_log[0].addr[10]), 32'd1);
    check_equal("o_sdram.cmd init 1", 32'(cmd_log[1].cmd), 32'(AUTO_REFRESH));
    check_equal("o_sdram.cmd init 2", 32'(cmd_log[2].cmd), 32'(AUTO_REFRESH));
    check_equal("o_sdram.cmd init 3", 32'(cmd_log[3].cmd), 32'(LOAD_MODE));
    check_equal("o_sdram.addr mode word", 32'(cmd_log[3].addr), 32'(MODE_WORD));
    check_equal("o_sdram.addr burst length", 32'(cmd_log[3].addr[2:0]), 32'd0);
    check_equal("o_sdram.addr burst type", 32'(cmd_log[3].addr[3]), 32'd0);
    check_equal("o_sdram.addr cas latency", 32'(cmd_log[3].addr[6:4]), 32'd3);
    check_equal("ACTIVE count during init", 32'(act_log.size()), 32'd0);
    check_equal("o_rsp_valid during init", 32'(rsp_count), 32'd0);
  endtask

  task automatic check_write_read();
    logic [ADDR_W-1:0] addr;
    addr = ADDR_W'($urandom());
    write_word(addr, DATA_W'($urandom()), 2'b00);
    read_word(addr);
    stop_requests();
    drain_responses();
  endtask

  task automatic check_byte_mask();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] old_word;
    logic [DATA_W-1:0] new_word;
    addr     = ADDR_W'($urandom());
    old_word = DATA_W'($urandom());
    new_word = ~old_word;   // every bit differs
    write_word(addr, old_word, 2'b00);
    write_word(addr, new_word, 2'b01);
    expected_q.push_back({new_word[15:8], old_word[7:0]});
    send_request(1'b0, addr, '0, '0);
    stop_requests();
    drain_responses();
  endtask

  task automatic check_bank_independence();
    logic [ADDR_W-1:0] addr [2];
    logic [DATA_W-1:0] data;
    addr[0]    = ADDR_W'($urandom());
    addr[0][8] = 1'b0;
    addr[1]    = addr[0];
    addr[1][8] = 1'b1;
    data       = DATA_W'($urandom());
    act_log.delete();
    write_word(addr[0], data, 2'b00);
    write_word(addr[1], ~data, 2'b00);
    read_word(addr[0]);
    read_word(addr[1]);
    stop_requests();
    drain_responses();
    check_equal("ACTIVE count", 32'(act_log.size()), 32'd4);
    for (int i = 0; i < 4; i++)
    begin
      check_equal("o_sdram.addr on ACTIVE", 32'(act_log[i].addr), 32'(addr[i % 2][20:9]));
      check_equal("o_sdram.ba on ACTIVE", 32'(act_log[i].ba),
                  32'({addr[i % 2][21], addr[i % 2][8]}));
    end
  endtask

  task automatic check_back_pressure();
    logic [ADDR_W-1:0] addr [6];
    int                stall_start;
    stall_start = stall_cycles;
    for (int i = 0; i < 6; i++)
      addr[i] = ADDR_W'($urandom());
    for (int i = 0; i < 12; i++)
    begin
      if (i % 2 == 0)
        write_word(addr[i / 2], DATA_W'($urandom()), 2'b00);
      else
        read_word(addr[i / 2]);
    end
    stop_requests();
    drain_responses();
    check_equal("o_req_ready low while valid", 32'(stall_cycles > stall_start), 32'd1);
  endtask

  task automatic check_refresh_traffic();
    logic [ADDR_W-1:0] addr;
    int                start_cycle;
    int                start_refreshes;
    start_cycle     = cycle;
    start_refreshes = refresh_count;
    while (cycle - start_cycle < TRAFFIC_CYCLES)
    begin
      addr = ADDR_W'($urandom());
      write_word(addr, DATA_W'($urandom()), 2'b00);
      read_word(addr);
    end
    stop_requests();
    drain_responses();
    check_equal("AUTO_REFRESH count in range",
                32'(refresh_count - start_refreshes >= TRAFFIC_CYCLES / REFRESH_CYCLES - 1),
                32'd1);
    check_equal("model error flag", 32'(model_error), 32'd0);
  endtask

  initial
  begin
    cycle         = 0;
    rsp_count     = 0;
    refresh_count = 0;
    stall_cycles  = 0;
    error_count   = 0;
    reset_n       = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    void'($urandom(32'h59332a9e));
    repeat (8) @(posedge clk);
    #1;
    check_reset_state();      // still inside reset
    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_init_sequence();
    check_write_read();
    check_byte_mask();
    check_bank_independence();
    check_back_pressure();
    check_refresh_traffic();
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
